// File: Makefile
# Verilator build and run for the serial transmitter

VERILATOR ?= verilator
TOP       ?= tb_uart_tx
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/baud_timer.sv
// Bit period timer
`default_nettype none

module baud_timer
    import uart_pkg::*;
(
    input  wire  aclk,
    input  wire  aresetn,
    input  wire  baud_start,
    output logic bit_tick
);

    baud_cnt_t cnt;
    logic      cnt_last;

    // Final cycle of a bit period
    assign cnt_last = (cnt == baud_cnt_t'(baud_div - 1));

    // Held at zero between frames
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt <= '0;
        end else if (!baud_start) begin
            cnt <= '0;
        end else if (cnt_last) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Pulse on the baud_div-th cycle of each bit
    assign bit_tick = baud_start & cnt_last;

endmodule

`default_nettype wire

// File: rtl/fifo_pkg.sv
// Byte buffer definitions
`default_nettype none

package fifo_pkg;

    //////////////////////////////////////////////////////////////////////
    // Buffer geometry
    //////////////////////////////////////////////////////////////////////

    // Address bits, depth is a power of two
    localparam int fifo_addr_width = 4;
    localparam int fifo_depth      = 2 ** fifo_addr_width;

    //////////////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////////////

    // One transmitted byte
    typedef logic [7:0]                 byte_t;
    typedef logic [fifo_addr_width-1:0] fifo_addr_t;
    // Extra MSB is the wrap bit
    typedef logic [fifo_addr_width:0]   fifo_ptr_t;

endpackage

`default_nettype wire

// File: rtl/fifo_rd_if.sv
// FIFO read side bundle
`default_nettype none

interface fifo_rd_if
    import fifo_pkg::*;
();

    // Head of the FIFO, valid while empty is low
    byte_t data;
    logic  empty;
    logic  aempty;
    // One-cycle strobe, ignored when empty
    logic  pull;

    modport fifo_side     (output data, output empty, output aempty, input  pull);
    modport consumer_side (input  data, input  empty, input  aempty, output pull);

endinterface

`default_nettype wire

// File: rtl/scfifo.sv
// Single clock byte FIFO
`default_nettype none

module scfifo
    import fifo_pkg::*;
(
    input  wire        aclk,
    input  wire        aresetn,
    input  wire        flush,
    input  wire byte_t data_in,
    input  wire        push,
    output logic       full,
    output logic       afull,
    fifo_rd_if.fifo_side rd
);

    //////////////////////////////////////////////////////////////////////
    // Declarations
    //////////////////////////////////////////////////////////////////////

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    // Number of stored entries
    fifo_ptr_t fill;
    logic      wr_en;
    logic      rd_en;

    // Accepted push and honored pull
    assign wr_en = push & ~full;
    assign rd_en = rd.pull & ~rd.empty;

    //////////////////////////////////////////////////////////////////////
    // Write pointer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
        end else if (flush) begin
            // Flush drops everything stored
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read pointer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_ptr <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            // Advances on the edge ending the pull cycle
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Flags
    //////////////////////////////////////////////////////////////////////

    // Wrap bit makes the distance unambiguous
    assign fill = wr_ptr - rd_ptr;

    assign full      = (fill == fifo_ptr_t'(fifo_depth));
    // One slot left
    assign afull     = (fill == fifo_ptr_t'(fifo_depth - 1));
    assign rd.empty  = (fill == '0);
    // Last entry in the buffer
    assign rd.aempty = (fill == fifo_ptr_t'(1));

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    scfifo_ram i_ram (
        .aclk     (aclk),
        .wr_en    (wr_en),
        .addr_in  (wr_ptr[fifo_addr_width-1:0]),
        .data_in  (data_in),
        .addr_out (rd_ptr[fifo_addr_width-1:0]),
        .data_out (rd.data)
    );

endmodule

`default_nettype wire

// File: rtl/scfifo_ram.sv
// FIFO storage array
`default_nettype none

module scfifo_ram
    import fifo_pkg::*;
(
    input  wire             aclk,
    input  wire             wr_en,
    input  wire fifo_addr_t addr_in,
    input  wire byte_t      data_in,
    input  wire fifo_addr_t addr_out,
    output byte_t           data_out
);

    // One byte per entry
    byte_t mem [fifo_depth];

    // Write port, clocked
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[addr_in] <= data_in;
        end
    end

    // Read port, no latency
    assign data_out = mem[addr_out];

endmodule

`default_nettype wire

// File: rtl/tx_shifter.sv
// Frame shift register
`default_nettype none

module tx_shifter
    import fifo_pkg::*;
    import uart_pkg::*;
(
    input  wire        aclk,
    input  wire        aresetn,
    input  wire        load,
    input  wire        shift,
    input  wire byte_t data,
    output logic       txd
);

    // Bit 0 drives the line
    logic [frame_bits-1:0] frame_q;

    //////////////////////////////////////////////////////////////////////
    // Load and shift
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            // Line idles high
            frame_q <= '1;
        end else if (load) begin
            // Stop, data LSB first, start
            frame_q <= {1'b1, data, 1'b0};
        end else if (shift) begin
            // Ones refill from the top
            frame_q <= {1'b1, frame_q[frame_bits-1:1]};
        end
    end

    assign txd = frame_q[0];

endmodule

`default_nettype wire

// File: rtl/uart_pkg.sv
// Serial transmitter definitions
`default_nettype none

package uart_pkg;

    //////////////////////////////////////////////////////////////////////
    // Frame timing
    //////////////////////////////////////////////////////////////////////

    // Clock cycles per bit
    localparam int baud_div   = 8;
    // Start, eight data bits, stop
    localparam int frame_bits = 10;

    //////////////////////////////////////////////////////////////////////
    // Counters and state
    //////////////////////////////////////////////////////////////////////

    typedef logic [$clog2(baud_div)-1:0]   baud_cnt_t;
    typedef logic [$clog2(frame_bits)-1:0] bit_cnt_t;

    // Transmit sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_send
    } tx_state_t;

endpackage

`default_nettype wire

// File: rtl/uart_tx_fsm.sv
// Transmit sequencer
`default_nettype none

module uart_tx_fsm
    import uart_pkg::*;
(
    input  wire  aclk,
    input  wire  aresetn,
    fifo_rd_if.consumer_side rd,
    output logic baud_start,
    input  wire  bit_tick,
    output logic load,
    output logic shift,
    output logic busy
);

    tx_state_t state;
    tx_state_t state_nxt;
    bit_cnt_t  bit_cnt;
    logic      take;
    logic      last_bit;

    // Byte is read from the FIFO head in st_load
    assign take     = (state == st_load) & ~rd.empty;
    // Tick closing the stop bit
    assign last_bit = bit_tick & (bit_cnt == bit_cnt_t'(frame_bits - 1));

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (!rd.empty) state_nxt = st_load;
            // A flush may have emptied the FIFO meanwhile
            st_load: state_nxt = rd.empty ? st_idle : st_send;
            st_send: if (last_bit) state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Bit index within the frame
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            bit_cnt <= '0;
        end else if (state != st_send) begin
            bit_cnt <= '0;
        end else if (bit_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    assign rd.pull    = take;
    assign load       = take;
    assign baud_start = (state == st_send);
    assign shift      = baud_start & bit_tick;
    assign busy       = (state != st_idle);

endmodule

`default_nettype wire

// File: rtl/uart_tx_top.sv
// Buffered serial transmitter
`default_nettype none

module uart_tx_top
    import fifo_pkg::*;
(
    input  wire        aclk,
    input  wire        aresetn,
    input  wire        flush,
    input  wire byte_t data_in,
    input  wire        push,
    output logic       full,
    output logic       afull,
    output logic       txd,
    output logic       busy
);

    // Sequencer to timer and shifter
    logic baud_start;
    logic bit_tick;
    logic load;
    logic shift;

    fifo_rd_if rd_bus ();

    // Byte buffer
    scfifo i_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .flush   (flush),
        .data_in (data_in),
        .push    (push),
        .full    (full),
        .afull   (afull),
        .rd      (rd_bus.fifo_side)
    );

    uart_tx_fsm i_fsm (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .rd         (rd_bus.consumer_side),
        .baud_start (baud_start),
        .bit_tick   (bit_tick),
        .load       (load),
        .shift      (shift),
        .busy       (busy)
    );

    baud_timer i_baud (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .baud_start (baud_start),
        .bit_tick   (bit_tick)
    );

    // FIFO head goes straight into the frame
    tx_shifter i_shifter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .load    (load),
        .shift   (shift),
        .data    (rd_bus.data),
        .txd     (txd)
    );

endmodule

`default_nettype wire

// File: sim.f
rtl/fifo_pkg.sv
rtl/uart_pkg.sv
rtl/fifo_rd_if.sv
rtl/scfifo_ram.sv
rtl/scfifo.sv
rtl/baud_timer.sv
rtl/tx_shifter.sv
rtl/uart_tx_fsm.sv
rtl/uart_tx_top.sv
verification/uart_tx_chk.sv
verification/tb_uart_tx.sv

// File: verification/tb_uart_tx.sv
// Serial transmitter testbench
`default_nettype none

module tb_uart_tx
    import fifo_pkg::*;
    import uart_pkg::*;
();

    localparam int clk_period  = 20;
    localparam int n_single    = 6;
    localparam int n_flush     = 5;
    localparam int n_recover   = 8;
    localparam int total_bytes = n_single + 3 * fifo_depth + n_flush + n_recover;
    // Two frame times per byte, plus slack for idle checks
    localparam int watchdog_cycles = total_bytes * frame_bits * baud_div * 2 + 1000;

    logic  aclk;
    logic  aresetn;
    logic  flush;
    logic  push;
    byte_t data_in;
    logic  full;
    logic  afull;
    logic  txd;
    logic  busy;

    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;
    int          rx_count = 0;
    int          accepted = 0;
    int          dropped = 0;
    bit          check_gap = 1'b0;
    bit          have_prev_end = 1'b0;
    time         prev_end = 0;
    int unsigned rng_state = 61;
    // Bytes accepted by the FIFO, oldest first
    byte_t       exp_q[$];

    uart_tx_top i_dut (
        .aclk    (aclk),
        .aresetn (aresetn),
        .flush   (flush),
        .data_in (data_in),
        .push    (push),
        .full    (full),
        .afull   (afull),
        .txd     (txd),
        .busy    (busy)
    );

    always #(clk_period / 2) aclk = ~aclk;

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////

    // LCG step
    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    // Push held high, model sees full at drive time
    task automatic push_byte(input byte_t value);
        @(posedge aclk);
        #2;
        data_in = value;
        push    = 1'b1;
        if (!full) begin
            exp_q.push_back(value);
            accepted++;
        end else begin
            dropped++;
        end
    endtask

    task automatic release_push();
        @(posedge aclk);
        #2;
        push = 1'b0;
    endtask

    task automatic run_burst(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            push_byte(byte_t'(next_rand()));
        end
        release_push();
    endtask

    // All accepted bytes decoded and sequencer back in idle
    task automatic wait_drained();
        while (exp_q.size() != 0 || busy !== 1'b0) begin
            @(negedge aclk);
        end
        repeat (4) @(negedge aclk);
    endtask

    task automatic observe_idle(input int cycles);
        repeat (cycles) begin
            @(negedge aclk);
            check_value("txd", 32'(txd), 32'd1);
            check_value("busy", 32'(busy), 32'd0);
            check_value("full", 32'(full), 32'd0);
            check_value("afull", 32'(afull), 32'd0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Line decoder model
    ////////////////////////////////////////////////////////////////////

    initial begin : line_decoder
        byte_t rx;
        time   t_start;
        wait (aresetn === 1'b1);
        forever begin
            @(negedge txd);
            t_start = $time;
            // Line high between stop bit and next start
            if (check_gap && have_prev_end) begin
                check_value("idle_gap", 32'((t_start - prev_end) / clk_period), 32'd2);
            end
            // Middle of the start bit
            repeat (baud_div / 2) @(negedge aclk);
            check_value("start_bit", 32'(txd), 32'd0);
            for (int i = 0; i < 8; i++) begin
                repeat (baud_div) @(negedge aclk);
                rx[i] = txd;
            end
            repeat (baud_div) @(negedge aclk);
            check_value("stop_bit", 32'(txd), 32'd1);
            if (exp_q.size() == 0) begin
                $display("Frame decoded at %0t although no byte was waiting", $time);
                error_count++;
            end else begin
                check_value("rx_byte", 32'(rx), 32'(exp_q.pop_front()));
            end
            rx_count++;
            // busy falls where the stop bit ends
            @(negedge busy);
            prev_end      = $time;
            have_prev_end = 1'b1;
            check_value("frame_cycles", 32'((prev_end - t_start) / clk_period),
                        32'(frame_bits * baud_div));
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        int rx_before;
        int acc_before;
        aclk    = 1'b0;
        aresetn = 1'b0;
        flush   = 1'b0;
        push    = 1'b0;
        data_in = '0;
        repeat (8) @(posedge aclk);
        #2;
        aresetn = 1'b1;

        observe_idle(20);
        finish_test("idle after reset");

        // Gaps longer than one frame
        rx_before = rx_count;
        for (int i = 0; i < n_single; i++) begin
            push_byte(byte_t'(next_rand()));
            release_push();
            repeat (frame_bits * baud_div + 4 + int'(next_rand() % 24)) @(posedge aclk);
        end
        wait_drained();
        check_value("frames", 32'(rx_count - rx_before), 32'(n_single));
        finish_test("single bytes");

        rx_before  = rx_count;
        acc_before = accepted;
        dropped    = 0;
        run_burst(2 * fifo_depth);
        // First byte sits in the shifter, the rest fill the buffer
        check_value("full", 32'(full), 32'd1);
        check_value("afull", 32'(afull), 32'd0);
        // Second pull leaves one slot free
        @(negedge busy);
        repeat (3) @(negedge aclk);
        check_value("full", 32'(full), 32'd0);
        check_value("afull", 32'(afull), 32'd1);
        wait_drained();
        check_value("frames", 32'(rx_count - rx_before), 32'(accepted - acc_before));
        check_value("dropped_seen", 32'(dropped > 0), 32'd1);
        check_value("full", 32'(full), 32'd0);
        finish_test("burst to full");

        rx_before     = rx_count;
        have_prev_end = 1'b0;
        check_gap     = 1'b1;
        run_burst(fifo_depth);
        wait_drained();
        check_gap = 1'b0;
        check_value("frames", 32'(rx_count - rx_before), 32'(fifo_depth));
        finish_test("frame spacing");

        rx_before = rx_count;
        for (int i = 0; i < n_flush; i++) begin
            push_byte(byte_t'(next_rand()));
        end
        release_push();
        while (busy !== 1'b1) begin
            @(posedge aclk);
            #2;
        end
        flush = 1'b1;
        // Only the byte already in the shifter survives
        while (exp_q.size() > 1) begin
            void'(exp_q.pop_back());
        end
        @(posedge aclk);
        #2;
        flush = 1'b0;
        wait_drained();
        check_value("frames", 32'(rx_count - rx_before), 32'd1);
        observe_idle(20);
        finish_test("flush");

        rx_before = rx_count;
        for (int i = 0; i < n_recover; i++) begin
            push_byte(byte_t'(next_rand()));
            release_push();
            repeat (int'(next_rand() % 4)) @(posedge aclk);
        end
        wait_drained();
        check_value("frames", 32'(rx_count - rx_before), 32'(n_recover));
        finish_test("recovery after flush");

        $display("Tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && i_dut.i_chk.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge aclk);
        $display("Timeout, the tests did not finish within %0d cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/uart_tx_chk.sv
// FIFO and line assertions
`default_nettype none

module uart_tx_chk (
    input wire aclk,
    input wire aresetn,
    input wire full,
    input wire afull,
    input wire empty,
    input wire pull,
    input wire busy,
    input wire txd
);

    // Failed property count
    int fail_count = 0;

    // Flag exclusivity
    a_full_empty: assert property (@(posedge aclk) disable iff (!aresetn) !(full && empty))
        else begin
            $error("full and empty high together");
            fail_count++;
        end
    a_afull_full: assert property (@(posedge aclk) disable iff (!aresetn) !(afull && full))
        else begin
            $error("afull and full high together");
            fail_count++;
        end

    // Sequencer never reads an empty buffer
    a_pull_empty: assert property (@(posedge aclk) disable iff (!aresetn) !(pull && empty))
        else begin
            $error("pull while empty");
            fail_count++;
        end

    // Idle line is high
    a_idle_high: assert property (@(posedge aclk) disable iff (!aresetn) busy || txd)
        else begin
            $error("txd low while not busy");
            fail_count++;
        end

endmodule

bind uart_tx_top uart_tx_chk i_chk (
    .aclk    (aclk),
    .aresetn (aresetn),
    .full    (full),
    .afull   (afull),
    .empty   (rd_bus.empty),
    .pull    (rd_bus.pull),
    .busy    (busy),
    .txd     (txd)
);

`default_nettype wire
